/* verilog/mbPkg.sv */
// mbPkg holds the word widths, select codes and channel word type of the memory buffer

package mbPkg;

  // machine word and half word widths
  localparam int wordWidth = 36;
  localparam int halfWidth = 18;

  // one 36-bit machine word, bit 35 is the leftmost bit
  typedef logic [wordWidth-1:0] mbWord;

  // half word as carried on the channel bus
  typedef logic [halfWidth-1:0] mbHalf;

  // channel word seen either whole or as two halves
  // left half sits in the upper bits
  typedef union packed {
    mbWord word;
    struct packed {
      mbHalf left;
      mbHalf right;
    } half;
  } chanWord;

  // MB input source codes on the two low bits of mbInSel
  localparam logic [1:0] inCache = 2'b00;
  // bit 2 of mbInSel chooses the channel buffer over AR for this code
  localparam logic [1:0] inArOrChan = 2'b01;
  localparam logic [1:0] inMem = 2'b10;
  localparam logic [1:0] inCcwMix = 2'b11;

  // memory-to-cache path sources
  localparam logic [1:0] cacheFromAr = 2'b00;
  localparam logic [1:0] cacheFromMb = 2'b01;
  localparam logic [1:0] cacheFromMem = 2'b10;
  localparam logic [1:0] cacheFromChReg = 2'b11;

endpackage : mbPkg

/* verilog/mbInSelect.sv */
// mbInSelect picks the word loaded into the MB registers and keeps the CCW buffer and mixer

module mbInSelect #(
  parameter int ccwDepth = 4
) (
  input  logic                        clk,
  input  logic                        arstN,
  // data sources
  input  mbPkg::mbWord                cacheData,
  input  mbPkg::mbWord                memDataIn,
  input  mbPkg::mbWord                ar,
  input  mbPkg::mbWord                mbChBuf,
  input  mbPkg::mbWord                mb,
  // source control
  input  logic [2:0]                  mbInSel,
  input  logic                        nxmAny,
  // CCW buffer
  input  logic                        ccwBufWr,
  input  logic [$clog2(ccwDepth)-1:0] ccwBufAdr,
  input  mbPkg::mbWord                ccwBufIn,
  input  logic                        mixMbSel,
  output mbPkg::mbWord                mbIn,
  output mbPkg::mbWord                ccwMix
);

  import mbPkg::*;

  // small CCW word store, written on the strobe edge
  mbWord ccwBuf [ccwDepth];

  // AR or channel buffer, the second source of code inArOrChan
  mbWord arOrChan;

  always_ff @(posedge clk) begin
    if (ccwBufWr) begin
      ccwBuf[ccwBufAdr] <= ccwBufIn;
    end
  end

  // mixer passes MB through or reads the addressed CCW word
  assign ccwMix = mixMbSel ? mb : ccwBuf[ccwBufAdr];

  assign arOrChan = mbInSel[2] ? mbChBuf : ar;

  // nonexistent memory forces an all-zero input word
  always_comb begin
    mbIn = '0;
    if (!nxmAny) begin
      case (mbInSel[1:0])
        inCache:    mbIn = cacheData;
        inArOrChan: mbIn = arOrChan;
        inMem:      mbIn = memDataIn;
        inCcwMix:   mbIn = ccwMix;
        default:    mbIn = '0;
      endcase
    end
  end

  // a CCW write must land on a known word, else the mixer reads garbage later
  ccwAdrKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    ccwBufWr |-> !$isunknown(ccwBufAdr)
  ) else $error("CCW buffer write with unknown address");

endmodule : mbInSelect

/* verilog/mbWordReg.sv */
// mbWordReg is one memory buffer register that captures the MB input word on its load strobe

module mbWordReg (
  input  logic         clk,
  input  logic         arstN,
  // load strobe for this register only
  input  logic         load,
  input  mbPkg::mbWord mbIn,
  output mbPkg::mbWord mbWord
);

  // holds its word until its own strobe comes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mbWord <= '0;
    end else if (load) begin
      mbWord <= mbIn;
    end
  end

endmodule : mbWordReg

/* verilog/mbOutSelect.sv */
// mbOutSelect drives the MB word from the selected register and feeds parity, cache and page table

module mbOutSelect #(
  parameter int numMbRegs = 4
) (
  input  logic                         clk,
  input  logic                         arstN,
  // every MB register, index is the register number
  input  mbPkg::mbWord                 mbWords [numMbRegs],
  input  logic                         mbSelLoad,
  input  logic [$clog2(numMbRegs)-1:0] mbSel,
  // other memory-to-cache sources
  input  mbPkg::mbWord                 ar,
  input  mbPkg::mbWord                 memDataIn,
  input  mbPkg::mbWord                 chReg,
  input  logic                         memToCacheEn,
  input  logic [1:0]                   memToCacheSel,
  input  logic                         kiPagingMode,
  output mbPkg::mbWord                 mb,
  output logic                         mbParOdd,
  output mbPkg::mbWord                 memToCache,
  output mbPkg::mbWord                 ptIn
);

  import mbPkg::*;

  // register number currently shown on mb
  logic [$clog2(numMbRegs)-1:0] selReg;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      selReg <= '0;
    end else if (mbSelLoad) begin
      selReg <= mbSel;
    end
  end

  assign mb = mbWords[selReg];

  // odd parity over the whole word
  assign mbParOdd = ^mb;

  // path into the cache, quiet when not enabled
  always_comb begin
    memToCache = '0;
    if (memToCacheEn) begin
      case (memToCacheSel)
        cacheFromAr:    memToCache = ar;
        cacheFromMb:    memToCache = mb;
        cacheFromMem:   memToCache = memDataIn;
        cacheFromChReg: memToCache = chReg;
        default:        memToCache = '0;
      endcase
    end
  end

  // KI paging takes the page table entry from MB, otherwise from AR
  assign ptIn = kiPagingMode ? mb : ar;

  // an unknown select would put X on mb for every cycle after the load
  mbSelKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    mbSelLoad |-> !$isunknown(mbSel)
  ) else $error("MB select loaded with unknown value");

endmodule : mbOutSelect

/* verilog/chanBuffer.sv */
// chanBuffer keeps the channel buffer RAM, the channel register and the registers around them

module chanBuffer #(
  parameter int chBufDepth = 128
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  mbPkg::mbWord                  mb,
  // buffer write side
  input  logic                          chBufWr,
  input  logic [$clog2(chBufDepth)-1:0] chBufAdr,
  input  logic                          chBufMbSel,
  // channel register load from the bus
  input  logic                          chRegLoad,
  input  logic                          chReverse,
  input  mbPkg::mbWord                  cbusIn,
  // buffer read side
  input  logic                          chBufLoad,
  input  logic                          cbusOutHold,
  output mbPkg::mbWord                  chReg,
  output mbPkg::mbWord                  mbChBuf,
  output mbPkg::mbWord                  cbusOut
);

  import mbPkg::*;

  // buffer storage, no reset
  mbWord chBuf [chBufDepth];

  // address is registered before it reaches the RAM
  logic [$clog2(chBufDepth)-1:0] adrReg;

  mbWord chBufIn;
  mbWord chBufRd;

  // bus word and its half-swapped form
  chanWord busWord;
  chanWord swapWord;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      adrReg <= '0;
    end else begin
      adrReg <= chBufAdr;
    end
  end

  // write data comes from MB or from the channel register
  assign chBufIn = chBufMbSel ? mb : chReg;

  always_ff @(posedge clk) begin
    if (chBufWr) begin
      chBuf[adrReg] <= chBufIn;
    end
  end

  assign chBufRd = chBuf[adrReg];

  // reverse mode exchanges left and right halves
  always_comb begin
    busWord.word = cbusIn;
    swapWord.half.left = busWord.half.right;
    swapWord.half.right = busWord.half.left;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      chReg <= '0;
    end else if (chRegLoad) begin
      chReg <= chReverse ? swapWord.word : busWord.word;
    end
  end

  // hold register carrying a buffer word towards MB
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mbChBuf <= '0;
    end else if (chBufLoad) begin
      mbChBuf <= chBufRd;
    end
  end

  // bus output follows the addressed word unless held
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cbusOut <= '0;
    end else if (!cbusOutHold) begin
      cbusOut <= chBufRd;
    end
  end

  // a write in the same cycle would store chReg from before the load
  noWrOnChLoad: assert property (
    @(posedge clk) disable iff (!arstN)
    !(chBufWr && chRegLoad)
  ) else $error("channel buffer write together with channel register load");

endmodule : chanBuffer

/* verilog/memBuffer.sv */
// memBuffer is the memory buffer datapath top with input select, MB registers and channel side

module memBuffer #(
  parameter int numMbRegs = 4,
  parameter int chBufDepth = 128,
  parameter int ccwDepth = 4
) (
  input  logic                          clk,
  input  logic                          arstN,
  // data sources
  input  mbPkg::mbWord                  cacheData,
  input  mbPkg::mbWord                  memDataIn,
  input  mbPkg::mbWord                  ar,
  // MB input and register control
  input  logic [2:0]                    mbInSel,
  input  logic                          nxmAny,
  input  logic [numMbRegs-1:0]          mbLoad,
  input  logic                          mbSelLoad,
  input  logic [$clog2(numMbRegs)-1:0]  mbSel,
  // CCW buffer and mixer
  input  logic                          ccwBufWr,
  input  logic [$clog2(ccwDepth)-1:0]   ccwBufAdr,
  input  mbPkg::mbWord                  ccwBufIn,
  input  logic                          mixMbSel,
  // cache and page table paths
  input  logic                          memToCacheEn,
  input  logic [1:0]                    memToCacheSel,
  input  logic                          kiPagingMode,
  // channel side
  input  logic                          chBufWr,
  input  logic [$clog2(chBufDepth)-1:0] chBufAdr,
  input  logic                          chBufMbSel,
  input  logic                          chRegLoad,
  input  logic                          chReverse,
  input  mbPkg::mbWord                  cbusIn,
  input  logic                          chBufLoad,
  input  logic                          cbusOutHold,
  output mbPkg::mbWord                  mb,
  output logic                          mbParOdd,
  output mbPkg::mbWord                  memToCache,
  output mbPkg::mbWord                  ptIn,
  output mbPkg::mbWord                  ccwMix,
  output mbPkg::mbWord                  cbusOut
);

  import mbPkg::*;

  mbWord mbIn;
  mbWord mbWords [numMbRegs];
  mbWord mbChBuf;
  mbWord chReg;

  mbInSelect #(
    .ccwDepth(ccwDepth)
  ) mbInSelect_inst (
    .clk(clk),
    .arstN(arstN),
    .cacheData(cacheData),
    .memDataIn(memDataIn),
    .ar(ar),
    .mbChBuf(mbChBuf),
    .mb(mb),
    .mbInSel(mbInSel),
    .nxmAny(nxmAny),
    .ccwBufWr(ccwBufWr),
    .ccwBufAdr(ccwBufAdr),
    .ccwBufIn(ccwBufIn),
    .mixMbSel(mixMbSel),
    .mbIn(mbIn),
    .ccwMix(ccwMix)
  );

  // one register per load bit, all fed from the same input word
  for (genvar k = 0; k < numMbRegs; k++) begin : mbRegs
    mbWordReg mbWordReg_inst (
      .clk(clk),
      .arstN(arstN),
      .load(mbLoad[k]),
      .mbIn(mbIn),
      .mbWord(mbWords[k])
    );
  end

  mbOutSelect #(
    .numMbRegs(numMbRegs)
  ) mbOutSelect_inst (
    .clk(clk),
    .arstN(arstN),
    .mbWords(mbWords),
    .mbSelLoad(mbSelLoad),
    .mbSel(mbSel),
    .ar(ar),
    .memDataIn(memDataIn),
    .chReg(chReg),
    .memToCacheEn(memToCacheEn),
    .memToCacheSel(memToCacheSel),
    .kiPagingMode(kiPagingMode),
    .mb(mb),
    .mbParOdd(mbParOdd),
    .memToCache(memToCache),
    .ptIn(ptIn)
  );

  chanBuffer #(
    .chBufDepth(chBufDepth)
  ) chanBuffer_inst (
    .clk(clk),
    .arstN(arstN),
    .mb(mb),
    .chBufWr(chBufWr),
    .chBufAdr(chBufAdr),
    .chBufMbSel(chBufMbSel),
    .chRegLoad(chRegLoad),
    .chReverse(chReverse),
    .cbusIn(cbusIn),
    .chBufLoad(chBufLoad),
    .cbusOutHold(cbusOutHold),
    .chReg(chReg),
    .mbChBuf(mbChBuf),
    .cbusOut(cbusOut)
  );

endmodule : memBuffer

/* sim/mbRefModel.svh */
// mbRefModel keeps the shadow state and the reference rules of the memory buffer datapath
`ifndef MB_REF_MODEL_SVH
`define MB_REF_MODEL_SVH

  // shadow copies of the DUT state
  mbWord shReg [4];
  int shSel;
  mbWord shCcw [4];
  mbWord shChBuf [128];
  mbWord shChReg;
  mbWord shMbChBuf;

  function automatic void clearShadow();
    shReg = '{default: '0};
    shCcw = '{default: '0};
    shSel = 0;
    shChReg = '0;
    shMbChBuf = '0;
  endfunction

  // odd parity as a running xor over the bits
  function automatic logic refParity(mbWord w);
    logic p;
    p = 1'b0;
    for (int i = 0; i < wordWidth; i++) begin
      p = p ^ w[i];
    end
    return p;
  endfunction

  // channel register word, halves exchanged in reverse mode
  function automatic mbWord refSwap(mbWord w, logic rev);
    chanWord u;
    u.word = w;
    if (rev) begin
      return {u.half.right, u.half.left};
    end
    return u.word;
  endfunction

  function automatic mbWord refCcwMix();
    return mixMbSel ? shReg[shSel] : shCcw[ccwBufAdr];
  endfunction

  // word offered to the MB registers by the current input select
  function automatic mbWord refMbIn();
    if (nxmAny) begin
      return '0;
    end
    case (mbInSel[1:0])
      inCache: return cacheData;
      inArOrChan: return mbInSel[2] ? shMbChBuf : ar;
      inMem: return memDataIn;
      default: return refCcwMix();
    endcase
  endfunction

  function automatic mbWord refMemToCache();
    if (!memToCacheEn) begin
      return '0;
    end
    case (memToCacheSel)
      cacheFromAr: return ar;
      cacheFromMb: return shReg[shSel];
      cacheFromMem: return memDataIn;
      default: return shChReg;
    endcase
  endfunction

  function automatic mbWord refPtIn();
    return kiPagingMode ? shReg[shSel] : ar;
  endfunction

`endif

/* sim/memBufferTb.sv */
// memBufferTb drives the memory buffer datapath and compares its outputs with a shadow model

module memBufferTb;

  timeunit 1ns;
  timeprecision 1ps;

  import mbPkg::*;

  // output codes for the comparison process
  localparam int outMb = 0;
  localparam int outPar = 1;
  localparam int outCache = 2;
  localparam int outPt = 3;
  localparam int outMix = 4;
  localparam int outCbus = 5;

  // summed length of the six tests in cycles
  localparam int testCycles = 16 + 16 + 13 + 21 + 7 + 14;
  // run limit is twice the test cycles plus the reset
  localparam int cycleLimit = 2 * testCycles + 16;

  logic clk;
  logic arstN;
  mbWord cacheData;
  mbWord memDataIn;
  mbWord ar;
  logic [2:0] mbInSel;
  logic nxmAny;
  logic [3:0] mbLoad;
  logic mbSelLoad;
  logic [1:0] mbSel;
  logic ccwBufWr;
  logic [1:0] ccwBufAdr;
  mbWord ccwBufIn;
  logic mixMbSel;
  logic memToCacheEn;
  logic [1:0] memToCacheSel;
  logic kiPagingMode;
  logic chBufWr;
  logic [6:0] chBufAdr;
  logic chBufMbSel;
  logic chRegLoad;
  logic chReverse;
  mbWord cbusIn;
  logic chBufLoad;
  logic cbusOutHold;
  mbWord mb;
  logic mbParOdd;
  mbWord memToCache;
  mbWord ptIn;
  mbWord ccwMix;
  mbWord cbusOut;

  // request handed from the stimulus to the comparison process
  logic chkReq;
  string chkName;
  int chkWhich;
  mbWord chkExp;
  int checkCount;
  int errCount;
  int checksAtStart;
  int errsAtStart;
  int cycles;
  logic [31:0] lfsr;

  `include "mbRefModel.svh"

  memBuffer memBuffer_inst (.*);

  always #50ns clk = ~clk;

  // galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  function automatic mbWord randomBits(int n);
    mbWord w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      w = {w[wordWidth-2:0], lfsr[0]};
    end
    return w;
  endfunction

  // output is compared at the coming rising edge
  task automatic checkOut(string name, int which, mbWord expVal);
    chkName = name;
    chkWhich = which;
    chkExp = expVal;
    chkReq = 1'b1;
    @(negedge clk);
    chkReq = 1'b0;
  endtask

  task automatic loadReg(int k, logic [2:0] sel);
    mbInSel = sel;
    mbLoad = '0;
    mbLoad[k] = 1'b1;
    shReg[k] = refMbIn();
    @(negedge clk);
    mbLoad = '0;
  endtask

  task automatic selectReg(int k);
    mbSel = 2'(k);
    mbSelLoad = 1'b1;
    shSel = k;
    @(negedge clk);
    mbSelLoad = 1'b0;
  endtask

  task automatic loadAndShow(string name, int k, logic [2:0] sel);
    loadReg(k, sel);
    if (shSel != k) begin
      selectReg(k);
    end
    checkOut(name, outMb, shReg[k]);
  endtask

  task automatic loadChReg(mbWord w, logic rev);
    cbusIn = w;
    chReverse = rev;
    chRegLoad = 1'b1;
    shChReg = refSwap(w, rev);
    @(negedge clk);
    chRegLoad = 1'b0;
  endtask

  // the address goes out one cycle ahead of the write strobe
  task automatic bufWrite(int adr, logic fromMb);
    chBufAdr = 7'(adr);
    @(negedge clk);
    chBufMbSel = fromMb;
    chBufWr = 1'b1;
    shChBuf[adr] = fromMb ? shReg[shSel] : shChReg;
    @(negedge clk);
    chBufWr = 1'b0;
  endtask

  task automatic bufToMb(int adr);
    chBufAdr = 7'(adr);
    @(negedge clk);
    chBufLoad = 1'b1;
    shMbChBuf = shChBuf[adr];
    @(negedge clk);
    chBufLoad = 1'b0;
  endtask

  task automatic endTest(string name);
    $display("test %s finished, %0d checks, %0d errors", name,
             checkCount - checksAtStart, errCount - errsAtStart);
    checksAtStart = checkCount;
    errsAtStart = errCount;
  endtask

  always @(posedge clk) begin
    mbWord actual;
    if (chkReq) begin
      case (chkWhich)
        outMb: actual = mb;
        outPar: actual = mbWord'(mbParOdd);
        outCache: actual = memToCache;
        outPt: actual = ptIn;
        outMix: actual = ccwMix;
        default: actual = cbusOut;
      endcase
      checkCount++;
      checkValue: assert (actual === chkExp) else begin
        $display("FAILED %s expected %h actual %h", chkName, chkExp, actual);
        errCount++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    cacheData = '0;
    memDataIn = '0;
    ar = '0;
    mbInSel = '0;
    nxmAny = 1'b0;
    mbLoad = '0;
    mbSelLoad = 1'b0;
    mbSel = '0;
    ccwBufWr = 1'b0;
    ccwBufAdr = '0;
    ccwBufIn = '0;
    mixMbSel = 1'b0;
    memToCacheEn = 1'b0;
    memToCacheSel = '0;
    kiPagingMode = 1'b0;
    chBufWr = 1'b0;
    chBufAdr = '0;
    chBufMbSel = 1'b0;
    chRegLoad = 1'b0;
    chReverse = 1'b0;
    cbusIn = '0;
    chBufLoad = 1'b0;
    cbusOutHold = 1'b0;
    chkReq = 1'b0;
    chkName = "";
    chkWhich = 0;
    chkExp = '0;
    checkCount = 0;
    errCount = 0;
    checksAtStart = 0;
    errsAtStart = 0;
    cycles = 0;
    lfsr = 32'hb54b_7ef2;
    clearShadow();
    repeat (16) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);

    // all registers are loaded before any is shown so later loads must leave the others alone
    for (int k = 0; k < 4; k++) begin
      cacheData = randomBits(wordWidth);
      loadReg(k, {1'b0, inCache});
    end
    for (int k = 0; k < 4; k++) begin
      selectReg(k);
      checkOut("regs mb", outMb, shReg[k]);
      checkOut("regs parity", outPar, mbWord'(refParity(shReg[k])));
    end
    endTest("registers");

    ar = randomBits(wordWidth);
    memDataIn = randomBits(wordWidth);
    cacheData = randomBits(wordWidth);
    mixMbSel = 1'b1;
    loadAndShow("sel cache", 1, {1'b0, inCache});
    loadAndShow("sel ar", 1, {1'b0, inArOrChan});
    loadAndShow("sel chbuf", 1, {1'b1, inArOrChan});
    loadAndShow("sel mem", 1, {1'b0, inMem});
    // mixer source shows register 0 which holds none of the other source words
    selectReg(0);
    loadAndShow("sel mix", 1, {1'b0, inCcwMix});
    nxmAny = 1'b1;
    loadAndShow("sel nxm", 2, {1'b0, inCache});
    nxmAny = 1'b0;
    mixMbSel = 1'b0;
    endTest("input select");

    for (int a = 0; a < 4; a++) begin
      ccwBufAdr = 2'(a);
      ccwBufIn = randomBits(wordWidth);
      ccwBufWr = 1'b1;
      shCcw[a] = ccwBufIn;
      @(negedge clk);
      ccwBufWr = 1'b0;
    end
    for (int a = 0; a < 4; a++) begin
      ccwBufAdr = 2'(a);
      checkOut("ccw read", outMix, refCcwMix());
    end
    // register 1 holds a nonzero word unlike the cleared register 2
    selectReg(1);
    mixMbSel = 1'b1;
    checkOut("ccw pass mb", outMix, refCcwMix());
    mixMbSel = 1'b0;
    ccwBufAdr = 2'd2;
    loadAndShow("ccw into mb", 3, {1'b0, inCcwMix});
    endTest("ccw mixer");

    loadChReg(randomBits(wordWidth), 1'b0);
    bufWrite(5, 1'b0);
    loadChReg(randomBits(wordWidth), 1'b1);
    bufWrite(6, 1'b0);
    bufWrite(7, 1'b1);
    for (int a = 5; a < 8; a++) begin
      bufToMb(a);
      loadAndShow("chan into mb", 0, {1'b1, inArOrChan});
    end
    endTest("channel buffer");

    memToCacheEn = 1'b1;
    for (int s = 0; s < 4; s++) begin
      memToCacheSel = 2'(s);
      checkOut("mem to cache", outCache, refMemToCache());
    end
    memToCacheEn = 1'b0;
    checkOut("mem to cache off", outCache, refMemToCache());
    for (int p = 0; p < 2; p++) begin
      kiPagingMode = p[0];
      checkOut("page table in", outPt, refPtIn());
    end
    endTest("cache and page table");

    // address and read register each take one edge before cbusOut moves
    bufWrite(10, 1'b1);
    loadChReg(randomBits(wordWidth), 1'b0);
    bufWrite(11, 1'b0);
    chBufAdr = 7'd10;
    repeat (2) @(negedge clk);
    checkOut("cbus track", outCbus, shChBuf[10]);
    cbusOutHold = 1'b1;
    chBufAdr = 7'd11;
    repeat (2) @(negedge clk);
    checkOut("cbus hold", outCbus, shChBuf[10]);
    cbusOutHold = 1'b0;
    repeat (2) @(negedge clk);
    checkOut("cbus track", outCbus, shChBuf[11]);
    endTest("channel bus out");

    $display("%0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : memBufferTb

/* compile.f */
+incdir+sim
verilog/mbPkg.sv
verilog/mbInSelect.sv
verilog/mbWordReg.sv
verilog/mbOutSelect.sv
verilog/chanBuffer.sv
verilog/memBuffer.sv
sim/memBufferTb.sv

/* Bender.yml */
package:
  name: mem_buffer

sources:
  - files:
      - verilog/mbPkg.sv
      - verilog/mbInSelect.sv
      - verilog/mbWordReg.sv
      - verilog/mbOutSelect.sv
      - verilog/chanBuffer.sv
      - verilog/memBuffer.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/memBufferTb.sv
